/* hw/sdh_bus_pkg.sv */
package sdh_bus_pkg;

	// bus data path
	localparam int DAT_W = 128;
	localparam int ADR_W = 5;

	// configuration register file
	localparam int NUM_REGS  = 16;
	localparam int REG_W     = 32; // upper bits of a register read are zero
	localparam int REG_IDX_W = $clog2(NUM_REGS);

	// special addresses above the register file
	localparam logic [ADR_W-1:0] ADR_CMD_EXEC  = 5'd16; // start a command
	localparam logic [ADR_W-1:0] ADR_FIFO_WR   = 5'd17; // push into transmit FIFO
	localparam logic [ADR_W-1:0] ADR_FIFO_RD   = 5'd18; // pop from receive FIFO
	localparam logic [ADR_W-1:0] ADR_DATA_EXEC = 5'd19; // start a data transfer

	// 20 to 31 are unmapped, answered with err

	typedef logic [DAT_W-1:0] sdh_word_t;

endpackage

/* hw/sdh_card_pkg.sv */
package sdh_card_pkg;

	// register numbers forwarded to the command engine
	localparam int REG_CMD_INDEX = 0;
	localparam int REG_CMD_ARG   = 1;

	// command field widths on the card side
	localparam int CMD_INDEX_W = 6;
	localparam int CMD_ARG_W   = 32;

	// transfer FIFOs
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = FIFO_PTR_W + 1; // must reach FIFO_DEPTH

	// receive side entry, data plus the line CRC verdict
	typedef struct packed {
		logic                    crc_bad;
		sdh_bus_pkg::sdh_word_t  data;
	} sdh_rx_entry_t;

endpackage

/* hw/sdh_xfer_fifo.sv */
`timescale 1ns/1ps

// circular buffer, head entry always visible on pop_data_o
module sdh_xfer_fifo
	import sdh_card_pkg::*;
#(
	parameter type entry_t = logic
)
(
	input  logic   wb_clock_i,
	input  logic   rst_n_i,
	input  logic   push_i,
	input  entry_t push_data_i,
	input  logic   pop_i,
	output entry_t pop_data_o,
	output logic   full_o,
	output logic   empty_o
);

	entry_t mem [FIFO_DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign full_o  = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign empty_o = (count == '0);

	// push on full is ignored, caller checks full_o first
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	assign pop_data_o = mem[rd_ptr];

	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or none
			endcase
		end
	end

	// storage
	always_ff @(posedge wb_clock_i)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

endmodule

/* hw/sdh_wb_decode.sv */
`timescale 1ns/1ps

module sdh_wb_decode
	import sdh_bus_pkg::*, sdh_card_pkg::*;
(
	input  logic                   wb_clock_i,
	input  logic                   rst_n_i,
	input  logic                   strobe_i,
	input  logic                   we_i,
	input  logic [ADR_W-1:0]       adr_i,
	input  sdh_word_t              dat_i,
	output sdh_word_t              dat_o,
	output logic                   ack_o,
	output logic                   err_o,
	output logic [CMD_INDEX_W-1:0] cmd_index_o,
	output logic [CMD_ARG_W-1:0]   cmd_arg_o,
	output logic                   cmd_req_o,
	output logic                   data_req_o,
	output logic                   push_req_o,
	output sdh_word_t              push_word_o,
	output logic                   pop_req_o,
	input  logic                   done_i,
	input  logic                   err_i,
	input  sdh_word_t              pop_word_i
);

	logic [REG_W-1:0] regs [NUM_REGS];
	logic [REG_W-1:0] rd_q;       // register read value, waits for the ack cycle
	logic             busy_q;     // bus cycle taken, cleared once strobe drops
	logic             wait_q;     // stage request outstanding
	logic             live_q;     // its bus cycle is still open
	logic [1:0]       loc_ack_q;  // local answers delayed to match the stage path
	logic [1:0]       loc_err_q;

	logic is_reg, is_cmd, is_data, is_push, is_pop, is_exec, is_special, unmapped;
	logic stage_hit, local_err, accept, stage_go;

	always_comb
	begin
		is_reg     = (adr_i < NUM_REGS);
		is_cmd     = (adr_i == ADR_CMD_EXEC);
		is_data    = (adr_i == ADR_DATA_EXEC);
		is_push    = (adr_i == ADR_FIFO_WR);
		is_pop     = (adr_i == ADR_FIFO_RD);
		is_exec    = is_cmd | is_data;
		is_special = is_exec | is_push | is_pop;
		unmapped   = (adr_i > ADR_DATA_EXEC);
		// execs and pushes are writes, a pop is a read
		stage_hit  = ((is_exec | is_push) & we_i) | (is_pop & ~we_i);
		// an open wait_q here means the master abandoned an exec, which is still running
		local_err  = unmapped | (is_special & ~stage_hit) | (is_exec & wait_q);
		// a push or pop stalls until the running exec answers
		accept     = strobe_i & ~busy_q & (is_reg | local_err | ~wait_q);
		stage_go   = accept & ~local_err & stage_hit;
	end

	assign cmd_index_o = regs[REG_CMD_INDEX][CMD_INDEX_W-1:0];
	assign cmd_arg_o   = regs[REG_CMD_ARG][CMD_ARG_W-1:0];

	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			regs       <= '{default: '0};
			busy_q     <= 1'b0;
			wait_q     <= 1'b0;
			live_q     <= 1'b0;
			loc_ack_q  <= '0;
			loc_err_q  <= '0;
			ack_o      <= 1'b0;
			err_o      <= 1'b0;
			cmd_req_o  <= 1'b0;
			data_req_o <= 1'b0;
			push_req_o <= 1'b0;
			pop_req_o  <= 1'b0;
		end
		else
		begin
			if (accept)
				busy_q <= 1'b1;
			else if (!strobe_i)
				busy_q <= 1'b0;

			// one-cycle request pulses
			cmd_req_o  <= stage_go & is_cmd;
			data_req_o <= stage_go & is_data;
			push_req_o <= stage_go & is_push;
			pop_req_o  <= stage_go & is_pop;

			loc_ack_q <= {loc_ack_q[0], accept & is_reg};
			loc_err_q <= {loc_err_q[0], accept & local_err};

			// answers to an abandoned cycle are swallowed
			ack_o <= loc_ack_q[1] | (done_i & live_q);
			err_o <= loc_err_q[1] | (err_i & live_q);

			if (stage_go)
			begin
				wait_q <= 1'b1;
				live_q <= 1'b1;
			end
			else if (done_i | err_i)
			begin
				wait_q <= 1'b0;
				live_q <= 1'b0;
			end
			else if (!strobe_i)
				live_q <= 1'b0;

			if (accept & is_reg & we_i)
				regs[adr_i[REG_IDX_W-1:0]] <= dat_i[REG_W-1:0];
		end
	end

	always_ff @(posedge wb_clock_i)
	begin
		if (stage_go)
			push_word_o <= dat_i;
		if (accept & is_reg)
			rd_q <= regs[adr_i[REG_IDX_W-1:0]];

		if (loc_ack_q[1])
			dat_o <= {{(DAT_W-REG_W){1'b0}}, rd_q}; // zero extended register
		else if (done_i | err_i)
			dat_o <= pop_word_i; // also kept on a crc_bad pop
	end

endmodule

/* hw/sdh_exec_ctrl.sv */
`timescale 1ns/1ps

module sdh_exec_ctrl
	import sdh_bus_pkg::*, sdh_card_pkg::*;
(
	input  logic          wb_clock_i,
	input  logic          rst_n_i,
	input  logic          cmd_req_i,
	input  logic          data_req_i,
	input  logic          push_req_i,
	input  sdh_word_t     push_word_i,
	input  logic          pop_req_i,
	output logic          done_o,
	output logic          err_o,
	output sdh_word_t     pop_word_o,
	output logic          cmd_start_o,
	input  logic          cmd_done_i,
	output logic          data_start_o,
	input  logic          data_done_i,
	output logic          tx_push_o,
	output sdh_word_t     tx_push_data_o,
	input  logic          tx_full_i,
	output logic          rx_pop_o,
	input  sdh_rx_entry_t rx_head_i,
	input  logic          rx_empty_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_CMD,
		ST_WAIT_DATA
	} exec_state_t;

	exec_state_t state;

	// FIFO side effects happen in the request cycle
	assign tx_push_o      = push_req_i & ~tx_full_i;
	assign tx_push_data_o = push_word_i;
	assign rx_pop_o       = pop_req_i & ~rx_empty_i;

	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state        <= ST_IDLE;
			cmd_start_o  <= 1'b0;
			data_start_o <= 1'b0;
			done_o       <= 1'b0;
			err_o        <= 1'b0;
		end
		else
		begin
			cmd_start_o  <= 1'b0;
			data_start_o <= 1'b0;
			done_o       <= 1'b0;
			err_o        <= 1'b0;

			case (state)
				ST_IDLE:
				begin
					if (cmd_req_i)
					begin
						cmd_start_o <= 1'b1;
						state       <= ST_WAIT_CMD;
					end
					else if (data_req_i)
					begin
						data_start_o <= 1'b1;
						state        <= ST_WAIT_DATA;
					end
				end
				ST_WAIT_CMD:
				begin
					if (cmd_done_i)
					begin
						done_o <= 1'b1; // command engine finished
						state  <= ST_IDLE;
					end
				end
				ST_WAIT_DATA:
				begin
					if (data_done_i)
					begin
						done_o <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase

			if (push_req_i)
			begin
				err_o  <= tx_full_i;
				done_o <= ~tx_full_i;
			end

			if (pop_req_i)
			begin
				err_o  <= rx_empty_i | rx_head_i.crc_bad;
				done_o <= ~rx_empty_i & ~rx_head_i.crc_bad;
			end
		end
	end

	always_ff @(posedge wb_clock_i)
	begin
		if (pop_req_i)
			pop_word_o <= rx_head_i.data; // head entry before it leaves
	end

endmodule

/* hw/sdh_host_top.sv */
`timescale 1ns/1ps

module sdh_host_top
	import sdh_bus_pkg::*, sdh_card_pkg::*;
(
	input  logic                   wb_clock_i,
	input  logic                   rst_n_i,
	input  logic                   strobe_i,
	input  logic                   we_i,
	input  logic [ADR_W-1:0]       adr_i,
	input  sdh_word_t              dat_i,
	output sdh_word_t              dat_o,
	output logic                   ack_o,
	output logic                   err_o,
	output logic [CMD_INDEX_W-1:0] cmd_index_o,
	output logic [CMD_ARG_W-1:0]   cmd_arg_o,
	output logic                   cmd_start_o,
	input  logic                   cmd_done_i,
	output logic                   data_start_o,
	input  logic                   data_done_i,
	output sdh_word_t              tx_data_o,
	output logic                   tx_valid_o,
	input  logic                   tx_ready_i,
	input  sdh_word_t              rx_data_i,
	input  logic                   rx_crc_bad_i,
	input  logic                   rx_valid_i,
	output logic                   rx_overrun_o
);

	logic          cmd_req, data_req, push_req, pop_req;
	logic          stage_done, stage_err;
	sdh_word_t     push_word, pop_word;
	logic          tx_push, tx_full, tx_empty;
	sdh_word_t     tx_push_data;
	logic          rx_pop, rx_full, rx_empty;
	sdh_rx_entry_t rx_head, rx_entry;

	assign tx_valid_o = ~tx_empty;

	assign rx_entry.data    = rx_data_i;
	assign rx_entry.crc_bad = rx_crc_bad_i;

	// no backpressure on receive, a word hitting a full FIFO is lost
	always_ff @(posedge wb_clock_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			rx_overrun_o <= 1'b0;
		else if (rx_valid_i & rx_full)
			rx_overrun_o <= 1'b1;
	end

	sdh_wb_decode sdh_wb_decode_i (
		.wb_clock_i (wb_clock_i),   .rst_n_i     (rst_n_i),
		.strobe_i   (strobe_i),     .we_i        (we_i),
		.adr_i      (adr_i),        .dat_i       (dat_i),
		.dat_o      (dat_o),        .ack_o       (ack_o),
		.err_o      (err_o),        .cmd_index_o (cmd_index_o),
		.cmd_arg_o  (cmd_arg_o),    .cmd_req_o   (cmd_req),
		.data_req_o (data_req),     .push_req_o  (push_req),
		.push_word_o(push_word),    .pop_req_o   (pop_req),
		.done_i     (stage_done),   .err_i       (stage_err),
		.pop_word_i (pop_word)
	);

	sdh_exec_ctrl sdh_exec_ctrl_i (
		.wb_clock_i    (wb_clock_i),  .rst_n_i       (rst_n_i),
		.cmd_req_i     (cmd_req),     .data_req_i    (data_req),
		.push_req_i    (push_req),    .push_word_i   (push_word),
		.pop_req_i     (pop_req),     .done_o        (stage_done),
		.err_o         (stage_err),   .pop_word_o    (pop_word),
		.cmd_start_o   (cmd_start_o), .cmd_done_i    (cmd_done_i),
		.data_start_o  (data_start_o),.data_done_i   (data_done_i),
		.tx_push_o     (tx_push),     .tx_push_data_o(tx_push_data),
		.tx_full_i     (tx_full),     .rx_pop_o      (rx_pop),
		.rx_head_i     (rx_head),     .rx_empty_i    (rx_empty)
	);

	// transmit queue drains straight to the card, independent of the exec FSM
	sdh_xfer_fifo #(.entry_t(sdh_word_t)) tx_fifo_i (
		.wb_clock_i (wb_clock_i),   .rst_n_i    (rst_n_i),
		.push_i     (tx_push),      .push_data_i(tx_push_data),
		.pop_i      (tx_ready_i & tx_valid_o),
		.pop_data_o (tx_data_o),
		.full_o     (tx_full),      .empty_o    (tx_empty)
	);

	sdh_xfer_fifo #(.entry_t(sdh_rx_entry_t)) rx_fifo_i (
		.wb_clock_i (wb_clock_i),   .rst_n_i    (rst_n_i),
		.push_i     (rx_valid_i),   .push_data_i(rx_entry),
		.pop_i      (rx_pop),       .pop_data_o (rx_head),
		.full_o     (rx_full),      .empty_o    (rx_empty)
	);

endmodule

/* verification/sdh_host_sva.sv */
`timescale 1ns/1ps

module sdh_host_sva
(
	input logic wb_clock_i,
	input logic rst_n_i,
	input logic strobe_i,
	input logic ack_i,
	input logic err_i,
	input logic cmd_start_i
);

	int assert_fails = 0; // read by the testbench at the end

	// a bus cycle ends with one answer only
	ack_err_excl: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		!(ack_i && err_i))
		else
		begin
			assert_fails++;
			$error("ack and err high in the same cycle");
		end

	ack_one_cycle: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		ack_i |=> !ack_i)
		else
		begin
			assert_fails++;
			$error("ack held longer than one cycle");
		end

	err_one_cycle: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		err_i |=> !err_i)
		else
		begin
			assert_fails++;
			$error("err held longer than one cycle");
		end

	// abandoned cycles must stay silent
	answer_in_cycle: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		(ack_i || err_i) |-> strobe_i)
		else
		begin
			assert_fails++;
			$error("answer given without an open bus cycle");
		end

	cmd_start_pulse: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
		cmd_start_i |=> !cmd_start_i)
		else
		begin
			assert_fails++;
			$error("cmd_start held longer than one cycle");
		end

endmodule

bind sdh_host_top sdh_host_sva sdh_host_sva_i (
	.wb_clock_i  (wb_clock_i),
	.rst_n_i     (rst_n_i),
	.strobe_i    (strobe_i),
	.ack_i       (ack_o),
	.err_i       (err_o),
	.cmd_start_i (cmd_start_o)
);

/* verification/sdh_host_tb.sv */
`timescale 1ns/1ps

module sdh_host_tb
	import sdh_bus_pkg::*, sdh_card_pkg::*;
();

	localparam int TRACE_MAX = 64;
	localparam int FIELDS    = 7; // name op adr data delay kind expected

	logic                   wb_clock_i = 1'b0;
	logic                   rst_n_i;
	logic                   strobe_i;
	logic                   we_i;
	logic [ADR_W-1:0]       adr_i;
	sdh_word_t              dat_i;
	sdh_word_t              dat_o;
	logic                   ack_o, err_o;
	logic [CMD_INDEX_W-1:0] cmd_index_o;
	logic [CMD_ARG_W-1:0]   cmd_arg_o;
	logic                   cmd_start_o, cmd_done_i;
	logic                   data_start_o, data_done_i;
	sdh_word_t              tx_data_o;
	logic                   tx_valid_o, tx_ready_i;
	sdh_word_t              rx_data_i;
	logic                   rx_crc_bad_i, rx_valid_i, rx_overrun_o;

	logic [127:0] trace_mem [TRACE_MAX*FIELDS];
	sdh_word_t    tx_expect [$];  // pushed words still owed by the transmit port
	sdh_word_t    tx_exp_word;
	string        cur_name = "reset";
	integer       seed = 32'h5838_6342;
	int           errors, checks, start_cnt, card_delay, tx_hold, cycle_cnt, cycle_limit;
	logic         was_cmd;

	sdh_host_top sdh_host_top_i (.*);

	always #5 wb_clock_i = ~wb_clock_i;

	function automatic string test_name(input int idx);
		case (idx)
			1:       return "reg_write_read";
			2:       return "cmd_fields";
			3:       return "cmd_exec";
			4:       return "data_exec";
			5:       return "exec_pending";
			6:       return "exec_read";
			7:       return "tx_push_held";
			8:       return "tx_full";
			9:       return "tx_order";
			10:      return "rx_pop";
			11:      return "rx_empty";
			12:      return "rx_crc_bad";
			13:      return "unmapped";
			default: return "unnamed";
		endcase
	endfunction

	task automatic compare_value(input string what, input logic [127:0] exp,
		input logic [127:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("FAIL %s %s: expected %0h actual %0h", cur_name, what, exp, act);
		end
	endtask

	// lat counts edges from the strobe sample to the answer
	task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
		input sdh_word_t wdata, output logic got_err, output sdh_word_t rdata,
		output int lat);
		int gap;
		gap = $random(seed) & 3;
		@(negedge wb_clock_i);
		repeat (gap) @(negedge wb_clock_i);
		strobe_i = 1'b1;
		we_i     = we;
		adr_i    = adr;
		dat_i    = wdata;
		lat      = 0;
		@(negedge wb_clock_i);
		while (!(ack_o || err_o))
		begin
			lat++;
			@(negedge wb_clock_i);
		end
		got_err = err_o;
		rdata   = dat_o;
		@(negedge wb_clock_i); // hold the strobe one more cycle before release
		strobe_i = 1'b0;
	endtask

	always @(posedge wb_clock_i)
	begin
		cycle_cnt++;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit)
		begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
			$display("Something failed");
			$finish;
		end
	end

	always @(posedge wb_clock_i)
		if (cmd_start_o || data_start_o)
			start_cnt++;

	// card engines pulse done card_delay cycles after a start
	always @(negedge wb_clock_i)
	begin
		if (cmd_start_o || data_start_o)
		begin
			was_cmd = cmd_start_o;
			repeat (card_delay) @(negedge wb_clock_i);
			if (was_cmd)
				cmd_done_i = 1'b1;
			else
				data_done_i = 1'b1;
			@(negedge wb_clock_i);
			cmd_done_i  = 1'b0;
			data_done_i = 1'b0;
		end
	end

	// transmit sink with a hold window
	always @(negedge wb_clock_i)
	begin
		if (tx_hold > 0)
		begin
			tx_ready_i = 1'b0;
			tx_hold    = tx_hold - 1;
		end
		else
			tx_ready_i = 1'b1;
		if (tx_ready_i && tx_valid_o) // moves on the next rising edge
		begin
			if (tx_expect.size() == 0)
			begin
				errors++;
				$display("FAIL %s: the transmit port sent a word that was never pushed",
					cur_name);
			end
			else
			begin
				tx_exp_word = tx_expect.pop_front();
				compare_value("tx word", tx_exp_word, tx_data_o);
			end
		end
	end

	initial
	begin
		int               line, base, op, dly, kind, lat, starts0, errs_before;
		int               rx_level;
		logic             got_err, exec_ok, rx_overrun_exp;
		logic [ADR_W-1:0] adr;
		sdh_word_t        data, expw, rdata;

		rst_n_i        = 1'b0;
		strobe_i       = 1'b0;
		we_i           = 1'b0;
		adr_i          = '0;
		dat_i          = '0;
		cmd_done_i     = 1'b0;
		data_done_i    = 1'b0;
		tx_ready_i     = 1'b1;
		rx_data_i      = '0;
		rx_crc_bad_i   = 1'b0;
		rx_valid_i     = 1'b0;
		rx_level       = 0;
		rx_overrun_exp = 1'b0;

		$readmemh("verification/sdh_host_trace.txt", trace_mem);
		for (line = 0; line < TRACE_MAX && trace_mem[line*FIELDS+1] != 128'hff; line++)
			cycle_limit += trace_mem[line*FIELDS+4] + 20;

		repeat (4) @(negedge wb_clock_i);
		rst_n_i = 1'b1;

		for (line = 0; line < TRACE_MAX && trace_mem[line*FIELDS+1] != 128'hff; line++)
		begin
			base        = line * FIELDS;
			cur_name    = test_name(trace_mem[base]);
			op          = trace_mem[base+1];
			adr         = trace_mem[base+2];
			data        = trace_mem[base+3];
			dly         = trace_mem[base+4];
			kind        = trace_mem[base+5];
			expw        = trace_mem[base+6];
			errs_before = errors;
			case (op)
				0:
				begin
					bus_access(1'b1, adr, data, got_err, rdata, lat);
					compare_value("write answer", 0, got_err);
					compare_value("write latency", 2, lat);
					bus_access(1'b0, adr, '0, got_err, rdata, lat);
					compare_value("read answer", 0, got_err);
					compare_value("read latency", 2, lat);
					compare_value("read data", expw, rdata);
				end
				1, 2, 3:
				begin
					card_delay = dly;
					starts0    = start_cnt;
					exec_ok    = (op == 1) && kind == 0 &&
						(adr == ADR_CMD_EXEC || adr == ADR_DATA_EXEC);
					if (op == 1 && adr == ADR_FIFO_WR && kind == 0)
						tx_expect.push_back(data);
					bus_access(op == 1, adr, data, got_err, rdata, lat);
					if (op != 1 && adr == ADR_FIFO_RD && rx_level > 0)
						rx_level--;
					compare_value("answer", kind, got_err);
					// exec answers three edges beyond the card delay
					compare_value("latency", exec_ok ? dly + 3 : 2, lat);
					compare_value("start pulses", exec_ok, start_cnt - starts0);
					if (op == 2)
						compare_value("read data", expw, rdata);
				end
				4:
				begin
					card_delay = dly;
					starts0    = start_cnt;
					@(negedge wb_clock_i);
					strobe_i = 1'b1;
					we_i     = 1'b1;
					adr_i    = adr;
					dat_i    = data;
					@(negedge wb_clock_i);
					while (!(cmd_start_o || data_start_o))
						@(negedge wb_clock_i);
					strobe_i = 1'b0; // master gives up before the ack
					repeat (2) @(negedge wb_clock_i);
					compare_value("start pulses", 1, start_cnt - starts0);
				end
				5: repeat (dly) @(negedge wb_clock_i);
				6:
				begin
					while (tx_expect.size() != 0)
						@(negedge wb_clock_i);
					@(negedge wb_clock_i);
				end
				7:
				begin
					@(posedge wb_clock_i);
					tx_hold = dly;
				end
				8:
				begin
					if (rx_level == FIFO_DEPTH)
						rx_overrun_exp = 1'b1; // word dropped at the full FIFO
					else
						rx_level++;
					@(negedge wb_clock_i);
					rx_data_i    = data;
					rx_crc_bad_i = (kind != 0);
					rx_valid_i   = 1'b1;
					@(negedge wb_clock_i);
					rx_valid_i   = 1'b0;
					compare_value("rx overrun", rx_overrun_exp, rx_overrun_o);
				end
				9: compare_value("cmd fields", expw[37:0], {cmd_index_o, cmd_arg_o});
				default:
				begin
					errors++;
					$display("Trace line %0d holds an unknown operation %0h", line, op);
				end
			endcase
			if (errors == errs_before)
				$display("ok   %s (trace line %0d)", cur_name, line);
			else
				$display("bad  %s (trace line %0d)", cur_name, line);
		end

		repeat (2) @(negedge wb_clock_i);
		errors += sdh_host_top_i.sdh_host_sva_i.assert_fails;
		$display("%0d tests, %0d checks, %0d failures", line, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* all.f */
hw/sdh_bus_pkg.sv
hw/sdh_card_pkg.sv
hw/sdh_xfer_fifo.sv
hw/sdh_wb_decode.sv
hw/sdh_exec_ctrl.sv
hw/sdh_host_top.sv
verification/sdh_host_sva.sv
verification/sdh_host_tb.sv

/* verification/sdh_host_trace.txt */
// name op adr data delay kind(0 ack, 1 err or crc_bad on inject) expected
// op 0 reg write+read, 1 write, 2 read+data, 3 read, 4 abandoned exec, 5 idle, 6 tx drain,
// op 7 tx hold, 8 rx inject, 9 cmd fields, ff end of trace
01 0 00 f0f0f0f0e1e1e1e1d2d2d2d2c0ffee25 00 0 c0ffee25
01 0 01 f0f0f0f0e1e1e1e1d2d2d2d212345678 00 0 12345678
01 0 02 f0f0f0f0e1e1e1e1d2d2d2d287654321 00 0 87654321
01 0 03 f0f0f0f0e1e1e1e1d2d2d2d20badf00d 00 0 0badf00d
01 0 04 f0f0f0f0e1e1e1e1d2d2d2d2deadbeef 00 0 deadbeef
01 0 05 f0f0f0f0e1e1e1e1d2d2d2d200000001 00 0 00000001
01 0 06 f0f0f0f0e1e1e1e1d2d2d2d280000000 00 0 80000000
01 0 07 f0f0f0f0e1e1e1e1d2d2d2d255aa55aa 00 0 55aa55aa
01 0 08 f0f0f0f0e1e1e1e1d2d2d2d2aa55aa55 00 0 aa55aa55
01 0 09 f0f0f0f0e1e1e1e1d2d2d2d213579bdf 00 0 13579bdf
01 0 0a f0f0f0f0e1e1e1e1d2d2d2d22468ace0 00 0 2468ace0
01 0 0b f0f0f0f0e1e1e1e1d2d2d2d2fedcba98 00 0 fedcba98
01 0 0c f0f0f0f0e1e1e1e1d2d2d2d201234567 00 0 01234567
01 0 0d f0f0f0f0e1e1e1e1d2d2d2d20f0f0f0f 00 0 0f0f0f0f
01 0 0e f0f0f0f0e1e1e1e1d2d2d2d2f0f0f0f0 00 0 f0f0f0f0
01 0 0f f0f0f0f0e1e1e1e1d2d2d2d2ffffffff 00 0 ffffffff
02 9 00 0 00 0 2512345678
03 1 10 0 05 0 0
04 1 13 0 0c 0 0
06 3 10 0 00 1 0
06 3 13 0 00 1 0
05 4 10 0 20 0 0
05 1 13 0 00 1 0
05 1 10 0 00 1 0
05 5 00 0 28 0 0
05 1 10 0 03 0 0
07 7 00 0 70 0 0
07 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d401 00 0 0
07 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d402 00 0 0
07 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d403 00 0 0
07 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d404 00 0 0
07 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d405 00 0 0
07 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d406 00 0 0
07 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d407 00 0 0
07 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d408 00 0 0
08 1 11 a1a1a1a1b2b2b2b2c3c3c3c3d4d4d409 00 1 0
09 6 00 0 00 0 0
0a 8 00 5a5a5a5a6b6b6b6b7c7c7c7c8d8d8d01 00 0 0
0a 8 00 5a5a5a5a6b6b6b6b7c7c7c7c8d8d8d02 00 0 0
0a 2 12 0 00 0 5a5a5a5a6b6b6b6b7c7c7c7c8d8d8d01
0a 2 12 0 00 0 5a5a5a5a6b6b6b6b7c7c7c7c8d8d8d02
0b 3 12 0 00 1 0
0c 8 00 5a5a5a5a6b6b6b6b7c7c7c7c8d8d8d03 00 1 0
0c 2 12 0 00 1 5a5a5a5a6b6b6b6b7c7c7c7c8d8d8d03
0d 1 14 0 00 1 0
0d 3 1f 0 00 1 0
ff ff 00 0 00 0 0
